// ==== exec_unit.f ====
rtl/exec_pkg.sv
rtl/exec_ctrl_if.sv
rtl/alu_core.sv
rtl/latency_timer.sv
rtl/exec_ctrl.sv
rtl/hold_reg.sv
rtl/exec_unit.sv
sim/exec_unit_sva.sv
sim/exec_unit_tb.sv

// ==== Makefile ====
LOG := sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module exec_unit_tb \
		-f exec_unit.f -o exec_unit_sim
	./obj_dir/exec_unit_sim +verilator+error+limit+1000 | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== sim/exec_unit_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_unit_tb;

    localparam int num_tests = 6;
    localparam int max_ops = 48;   // functions test is the longest
    localparam int watchdog_cycles = num_tests * max_ops * (exec_pkg::alu_latency + 10) + 100;

    logic        clk_in = 1'b0;
    logic        rst_in = 1'b1;
    logic        valid_in = 1'b0;
    logic        read_in = 1'b0;
    logic [31:0] rval1_in = '0;
    logic [31:0] rval2_in = '0;
    logic [3:0]  alu_func_in = '0;
    logic [2:0]  rob_idx_in = '0;
    wire  [31:0] data_out;
    wire  [2:0]  rob_idx_out;
    wire         ready_out;
    wire         valid_out;

    logic [31:0] lfsr_state = 32'h465c09e2;
    logic [31:0] exp_data_q[$];    // expected results, oldest first
    logic [2:0]  exp_idx_q[$];
    int unsigned issued_count = 0;
    int unsigned accepted_count = 0;
    int unsigned check_count = 0;
    int unsigned error_count = 0;
    int unsigned err_mark = 0;
    int unsigned op_mark = 0;

    exec_unit exec_unit_inst (.*);

    always #5 clk_in = ~clk_in;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        take_bits = v;
    endfunction

    // rv32 rules, codes in enum order add..sra
    function automatic logic [31:0] expected_result(input logic [31:0] a, input logic [31:0] b,
                                                    input logic [3:0] code);
        logic [4:0]  sh;
        logic [31:0] fill;
        sh = b[4:0];
        fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;   // sign bits for sra
        case (code)
            4'd0: expected_result = a + b;
            4'd1: expected_result = a + ~b + 32'd1;
            4'd2: expected_result = a & b;
            4'd3: expected_result = a | b;
            4'd4: expected_result = a ^ b;
            4'd5: expected_result = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
            4'd6: expected_result = {31'd0, a < b};
            4'd7: expected_result = a << sh;
            4'd8: expected_result = a >> sh;
            4'd9: expected_result = (a >> sh) | fill;
            default: expected_result = 32'd0;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, act);
        error_count++;
    endtask

    task automatic begin_test();
        err_mark = error_count;
        op_mark = issued_count;
    endtask

    task automatic end_test(input string name);
        $display("%-13s %0d ops, %0d errors", name, issued_count - op_mark, error_count - err_mark);
    endtask

    // issue one op, optionally poke valid_in while busy and done, then read
    task automatic run_op(input logic [3:0] code, input logic [31:0] a, input logic [31:0] b,
                          input logic [2:0] idx, input int unsigned read_delay,
                          input logic stray);
        int unsigned waited;
        waited = 0;
        while (!ready_out) @(negedge clk_in);
        valid_in    = 1'b1;
        rval1_in    = a;
        rval2_in    = b;
        alu_func_in = code;
        rob_idx_in  = idx;
        @(negedge clk_in);
        valid_in = 1'b0;
        issued_count++;
        while (!valid_out) begin
            waited++;
            valid_in = stray && (waited == 4);
            rval1_in = stray ? take_bits(32) : rval1_in;   // must not reach the ALU
            @(negedge clk_in);
        end
        repeat (read_delay) begin
            valid_in = stray;
            @(negedge clk_in);
        end
        valid_in = 1'b0;
        read_in  = 1'b1;
        @(negedge clk_in);
        read_in = 1'b0;
    endtask

    // scoreboard, accept edge and read edge
    always @(posedge clk_in) begin : scoreboard
        logic [31:0] exp_data;
        logic [2:0]  exp_idx;
        if (!rst_in && valid_in && ready_out) begin
            exp_data_q.push_back(expected_result(rval1_in, rval2_in, alu_func_in));
            exp_idx_q.push_back(rob_idx_in);
            accepted_count++;
        end
        if (!rst_in && valid_out && read_in) begin
            exp_data = exp_data_q.pop_front();
            exp_idx  = exp_idx_q.pop_front();
            check_count++;
            assert (data_out == exp_data) else report_mismatch("data_out", exp_data, data_out);
            assert (rob_idx_out == exp_idx)
                else report_mismatch("rob_idx_out", {29'd0, exp_idx}, {29'd0, rob_idx_out});
        end
    end

    initial begin : stimulus
        int unsigned total;
        repeat (10) @(negedge clk_in);
        rst_in = 1'b0;

        begin_test();
        assert (ready_out === 1'b1) else report_mismatch("ready_out", 32'd1, {31'd0, ready_out});
        assert (valid_out === 1'b0) else report_mismatch("valid_out", 32'd0, {31'd0, valid_out});
        end_test("reset");

        begin_test();
        for (int code = 0; code < 10; code++) begin
            repeat (4) run_op(4'(code), take_bits(32), take_bits(32), 3'(take_bits(3)), 0, 1'b0);
        end
        // negative compares, shift amounts of 32 and up
        run_op(4'd5, 32'hffff_fffb, 32'd3, 3'd1, 0, 1'b0);
        run_op(4'd6, 32'hffff_fffb, 32'd3, 3'd2, 0, 1'b0);
        run_op(4'd9, 32'h8000_0010, 32'h0000_0024, 3'd3, 0, 1'b0);
        run_op(4'd8, 32'h8000_0010, 32'hffff_ff24, 3'd4, 0, 1'b0);
        run_op(4'd7, 32'h0000_0001, 32'h0000_003f, 3'd5, 0, 1'b0);
        end_test("functions");

        begin_test();
        for (int code = 10; code < 16; code++) begin
            run_op(4'(code), take_bits(32), take_bits(32), 3'(take_bits(3)), 0, 1'b0);
        end
        end_test("undefined");

        begin_test();
        for (int i = 0; i < 8; i++) begin
            run_op(4'(take_bits(32) % 10), take_bits(32), take_bits(32), 3'(i), 0, 1'b0);
        end
        end_test("index");

        begin_test();
        repeat (10) run_op(4'(take_bits(32) % 10), take_bits(32), take_bits(32),
                           3'(take_bits(3)), take_bits(3), 1'b1);
        end_test("backpressure");

        begin_test();
        repeat (6) run_op(4'(take_bits(4)), take_bits(32), take_bits(32), 3'(take_bits(3)),
                          0, 1'b0);
        end_test("latency");

        repeat (3) @(negedge clk_in);
        assert (accepted_count == issued_count) else begin
            $display("DUT accepted %0d operations, %0d issued", accepted_count, issued_count);
            error_count++;
        end
        total = error_count + exec_unit_inst.sva_inst.fail_count;
        $display("tests %0d, operations %0d, checks %0d, errors %0d",
                 num_tests, issued_count, check_count, total);
        if (total == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(watchdog_cycles * 10);
        $display("timeout: tests did not finish within %0d cycles", watchdog_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/exec_unit_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_unit_sva (
    input wire                              clk_in,
    input wire                              rst_in,
    input wire                              valid_in,
    input wire                              read_in,
    input wire                              ready_out,
    input wire                              valid_out,
    input wire [exec_pkg::xlen-1:0]         data_out,
    input wire [exec_pkg::rob_idx_w-1:0]    rob_idx_out
);

    int unsigned fail_count = 0;   // failed assertion tally
    logic        accept;

    assign accept = valid_in && ready_out;

    a_exclusive: assert property (@(posedge clk_in) disable iff (rst_in)
        !(ready_out && valid_out))
        else begin $error("ready_out and valid_out high together"); fail_count++; end

    // result edge is alu_latency edges after accept, sampled one edge later
    a_lat_rise: assert property (@(posedge clk_in) disable iff (rst_in)
        $rose(valid_out) |-> $past(accept, exec_pkg::alu_latency + 1))
        else begin $error("valid_out rose without an accept at the latency"); fail_count++; end

    a_lat_done: assert property (@(posedge clk_in) disable iff (rst_in)
        $past(accept, exec_pkg::alu_latency + 1) |-> $rose(valid_out))
        else begin $error("valid_out missed the fixed latency"); fail_count++; end

    a_hold: assert property (@(posedge clk_in) disable iff (rst_in)
        valid_out && !read_in |=> $stable(data_out) && $stable(rob_idx_out))
        else begin $error("result changed under back-pressure"); fail_count++; end

    a_read: assert property (@(posedge clk_in) disable iff (rst_in)
        valid_out && read_in |=> !valid_out && ready_out)
        else begin $error("read did not return the unit to ready"); fail_count++; end

endmodule

bind exec_unit exec_unit_sva sva_inst (
    .clk_in      (clk_in),
    .rst_in      (rst_in),
    .valid_in    (valid_in),
    .read_in     (read_in),
    .ready_out   (ready_out),
    .valid_out   (valid_out),
    .data_out    (data_out),
    .rob_idx_out (rob_idx_out)
);

`default_nettype wire

// ==== rtl/exec_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_unit (
    input  wire                              clk_in,
    input  wire                              rst_in,
    input  wire                              valid_in,
    input  wire                              read_in,
    input  wire [exec_pkg::xlen-1:0]         rval1_in,
    input  wire [exec_pkg::xlen-1:0]         rval2_in,
    input  wire [3:0]                        alu_func_in,
    input  wire [exec_pkg::rob_idx_w-1:0]    rob_idx_in,
    output logic [exec_pkg::xlen-1:0]        data_out,
    output logic [exec_pkg::rob_idx_w-1:0]   rob_idx_out,
    output logic                             ready_out,
    output logic                             valid_out
);

    exec_ctrl_if ctrl_if ();

    exec_pkg::op_t               op_d;
    exec_pkg::op_t               op_q;
    logic [exec_pkg::xlen-1:0]   alu_res;
    exec_pkg::res_t              res_d;
    exec_pkg::res_t              res_q;

    // operand bundle from the issue port
    assign op_d.rval1   = rval1_in;
    assign op_d.rval2   = rval2_in;
    assign op_d.func    = exec_pkg::alu_func_e'(alu_func_in);
    assign op_d.rob_idx = rob_idx_in;

    assign res_d.data    = alu_res;
    assign res_d.rob_idx = op_q.rob_idx;

    exec_ctrl ctrl_inst (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .valid_in  (valid_in),
        .read_in   (read_in),
        .ready_out (ready_out),
        .valid_out (valid_out),
        .ctrl      (ctrl_if.ctrl)
    );

    latency_timer timer_inst (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .ctrl   (ctrl_if.timer)
    );

    hold_reg #(.payload_t(exec_pkg::op_t)) op_reg_inst (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .load   (ctrl_if.op_load),
        .d      (op_d),
        .q      (op_q)
    );

    alu_core alu_inst (
        .op     (op_q),
        .result (alu_res)
    );

    hold_reg #(.payload_t(exec_pkg::res_t)) res_reg_inst (
        .clk_in (clk_in),
        .rst_in (rst_in),
        .load   (ctrl_if.res_load),
        .d      (res_d),
        .q      (res_q)
    );

    assign data_out    = res_q.data;
    assign rob_idx_out = res_q.rob_idx;

endmodule

`default_nettype wire

// ==== rtl/hold_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

// load-enabled register for a packed payload
module hold_reg #(
    parameter type payload_t = logic
) (
    input  wire      clk_in,
    input  wire      rst_in,
    input  wire      load,
    input  wire      payload_t d,
    output payload_t q
);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            q <= '0;
        end else if (load) begin
            q <= d;
        end
        // otherwise hold for back-pressure
    end

endmodule

`default_nettype wire

// ==== rtl/exec_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_ctrl (
    input  wire         clk_in,
    input  wire         rst_in,
    input  wire         valid_in,   // one cycle issue pulse
    input  wire         read_in,
    output logic        ready_out,
    output logic        valid_out,  // held until read
    exec_ctrl_if.ctrl   ctrl
);

    typedef enum logic [1:0] {
        st_idle,
        st_busy,
        st_done
    } state_t;

    state_t state;
    logic   accept;
    logic   consume;

    // issue outside idle is dropped
    assign accept  = (state == st_idle) && valid_in;
    assign consume = (state == st_done) && read_in;

    assign ctrl.op_load     = accept;
    assign ctrl.timer_start = accept;
    assign ctrl.res_load    = (state == st_busy) && ctrl.timer_done;

    assign ready_out = (state == st_idle);
    assign valid_out = (state == st_done);

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_busy;
                    end
                end
                st_busy: begin
                    if (ctrl.res_load) begin
                        state <= st_done;   // result lands this edge
                    end
                end
                st_done: begin
                    if (consume) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/latency_timer.sv ====
`timescale 1ns/1ns
`default_nettype none

module latency_timer (
    input wire          clk_in,
    input wire          rst_in,
    exec_ctrl_if.timer  ctrl
);

    exec_pkg::lat_cnt_t count;   // zero means idle

    // loaded on the accept edge, so count==1 is the cycle before the
    // alu_latency-th edge after accept
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            count <= '0;
        end else if (ctrl.timer_start) begin
            count <= exec_pkg::lat_load;
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign ctrl.timer_done = (count == exec_pkg::lat_cnt_t'(1));

endmodule

`default_nettype wire

// ==== rtl/alu_core.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_core (
    input  wire exec_pkg::op_t           op,
    output logic [exec_pkg::xlen-1:0]    result
);

    logic [4:0] shamt;   // rv32 shifts use five bits
    logic       lt_s;
    logic       lt_u;

    assign shamt = op.rval2[4:0];

    // signed and unsigned compares for slt / sltu
    assign lt_s = $signed(op.rval1) < $signed(op.rval2);
    assign lt_u = op.rval1 < op.rval2;

    always_comb begin
        case (op.func)
            exec_pkg::func_add:  result = op.rval1 + op.rval2;
            exec_pkg::func_sub:  result = op.rval1 - op.rval2;
            exec_pkg::func_and:  result = op.rval1 & op.rval2;
            exec_pkg::func_or:   result = op.rval1 | op.rval2;
            exec_pkg::func_xor:  result = op.rval1 ^ op.rval2;
            exec_pkg::func_slt: begin
                result = {{(exec_pkg::xlen-1){1'b0}}, lt_s};
            end
            exec_pkg::func_sltu: begin
                result = {{(exec_pkg::xlen-1){1'b0}}, lt_u};
            end
            exec_pkg::func_sll:  result = op.rval1 << shamt;
            exec_pkg::func_srl:  result = op.rval1 >> shamt;   // zero fill
            exec_pkg::func_sra: begin
                // sign fill from bit 31
                result = $signed(op.rval1) >>> shamt;
            end
            default:             result = '0;   // codes 10..15
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/exec_ctrl_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// control strobes shared by the controller, timer and holding registers
interface exec_ctrl_if;

    logic op_load;      // capture operand bundle
    logic timer_start;  // begin latency count
    logic timer_done;   // one cycle before the result edge
    logic res_load;     // capture result bundle

    modport ctrl (
        output op_load,
        output timer_start,
        output res_load,
        input  timer_done
    );

    modport timer (
        input  timer_start,
        output timer_done
    );

    // holding registers only watch the load strobes
    modport hold (
        input op_load,
        input res_load
    );

endinterface

`default_nettype wire

// ==== rtl/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

    localparam int xlen = 32;       // operand and result width
    localparam int rob_idx_w = 3;   // reorder buffer index width

    // accept edge to valid edge, in clock edges
    localparam int alu_latency = 25;

    // counter sized to hold the full latency value
    localparam int lat_cnt_w = $clog2(alu_latency + 1);
    typedef logic [lat_cnt_w-1:0] lat_cnt_t;
    localparam lat_cnt_t lat_load = lat_cnt_t'(alu_latency);

    // encodings follow the existing rob issue logic
    typedef enum logic [3:0] {
        func_add  = 4'd0,
        func_sub  = 4'd1,
        func_and  = 4'd2,
        func_or   = 4'd3,
        func_xor  = 4'd4,
        func_slt  = 4'd5,
        func_sltu = 4'd6,
        func_sll  = 4'd7,
        func_srl  = 4'd8,
        func_sra  = 4'd9
    } alu_func_e;

    typedef struct packed {
        logic [xlen-1:0]      rval1;
        logic [xlen-1:0]      rval2;
        alu_func_e            func;
        logic [rob_idx_w-1:0] rob_idx;
    } op_t;

    typedef struct packed {
        logic [xlen-1:0]      data;
        logic [rob_idx_w-1:0] rob_idx;   // travels back with the result
    } res_t;

endpackage

`default_nettype wire
